// File: hdl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_SIZE      16
`define CONTROL_WIDTH  14
`define MEM_DEPTH      256  // Words in the memory model

// Opcodes in instruction[15:12]
`define BNE_OP    4'd0
`define BEQ_OP    4'd1
`define BGZ_OP    4'd2
`define BLZ_OP    4'd3
`define ADI_OP    4'd4
`define ORI_OP    4'd5
`define LHI_OP    4'd6
`define LWD_OP    4'd7
`define SWD_OP    4'd8
`define JMP_OP    4'd9
`define JAL_OP    4'd10
`define RTYPE_OP  4'd15

// R-type function codes in instruction[5:0]
`define FUNC_ADD  6'd0
`define FUNC_SUB  6'd1
`define FUNC_AND  6'd2
`define FUNC_ORR  6'd3
`define FUNC_NOT  6'd4
`define FUNC_TCP  6'd5
`define FUNC_SHL  6'd6
`define FUNC_SHR  6'd7
`define FUNC_JPR  6'd25
`define FUNC_JRL  6'd26
`define FUNC_WWD  6'd28
`define FUNC_HLT  6'd29

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_NOT   4'd4
`define ALU_TCP   4'd5
`define ALU_ALS   4'd6
`define ALU_ARS   4'd7
`define ALU_ZERO  4'd8

// Control word bit positions
`define CTL_ALU_SRC_IMM  0
`define CTL_ALU_OP_LSB   1
`define CTL_ALU_OP_MSB   4
`define CTL_REG_WRITE    5
`define CTL_MEM_TO_REG   6
`define CTL_MEM_WRITE    7
`define CTL_LOAD_UPPER   8
`define CTL_LINK         9
`define CTL_BRANCH       10
`define CTL_JUMP         11
`define CTL_PC_FROM_REG  12
`define CTL_OUTPUT       13

`endif

// File: hdl/cpuPkg.sv
`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [`WORD_SIZE-1:0] word_t;  // Data or address word
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [1:0] regIdx_t;  // One of four registers
	typedef logic [3:0] aluOp_t;
	typedef logic [`CONTROL_WIDTH-1:0] controlWord_t;

	// Micro-sequencer steps of one instruction
	typedef enum logic [2:0] {
		IF1,
		IF2,
		IF3,
		ID,
		EX,
		MEM1,
		MEM2,
		WB
	} microState_t;

endpackage

// File: hdl/alu.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module alu (
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	input  cpuPkg::aluOp_t op,
	output cpuPkg::word_t  result
);

	always_comb begin
		case (op)
			`ALU_ADD:  result = a + b;
			`ALU_SUB:  result = a - b;
			`ALU_AND:  result = a & b;
			`ALU_OR:   result = a | b;
			`ALU_NOT:  result = ~a;
			`ALU_TCP:  result = ~a + 1'b1;  // Two's complement
			`ALU_ALS:  result = a <<< 1;
			`ALU_ARS:  result = $signed(a) >>> 1;  // Keeps the sign bit
			`ALU_ZERO: result = '0;
			default:   result = '0;
		endcase
	end
endmodule

// File: hdl/registerFile.sv
`timescale 1ns/10ps

module registerFile (
	input  logic            clk,
	input  logic            reset_n,
	input  cpuPkg::regIdx_t readIdx1,
	input  cpuPkg::regIdx_t readIdx2,
	input  cpuPkg::regIdx_t writeIdx,
	input  logic            writeEnable,
	input  cpuPkg::word_t   writeData,
	output cpuPkg::word_t   readData1,
	output cpuPkg::word_t   readData2
);
	cpuPkg::word_t regs [4];

	assign readData1 = regs[readIdx1];  // Asynchronous reads
	assign readData2 = regs[readIdx2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeIdx] <= writeData;
		end
	end
endmodule

// File: hdl/controlUnit.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module controlUnit (
	input  logic                 clk,
	input  logic                 reset_n,
	input  cpuPkg::word_t        instruction,
	output cpuPkg::microState_t  microState,
	output cpuPkg::controlWord_t controls,
	output cpuPkg::word_t        numInst,
	output logic                 isHalted
);
	cpuPkg::opcode_t      opcode;
	cpuPkg::func_t        func;
	cpuPkg::aluOp_t       rAluOp;
	cpuPkg::controlWord_t decoded;
	cpuPkg::microState_t  nextState;
	logic                 isJump;
	logic                 isHlt;

	assign opcode = instruction[15:12];
	assign func = instruction[5:0];
	assign isJump = (opcode == `JMP_OP) || (opcode == `JAL_OP);  // Skip ID
	assign isHlt = (opcode == `RTYPE_OP) && (func == `FUNC_HLT);

	always_comb begin
		case (func)
			`FUNC_ADD: rAluOp = `ALU_ADD;
			`FUNC_SUB: rAluOp = `ALU_SUB;
			`FUNC_AND: rAluOp = `ALU_AND;
			`FUNC_ORR: rAluOp = `ALU_OR;
			`FUNC_NOT: rAluOp = `ALU_NOT;
			`FUNC_TCP: rAluOp = `ALU_TCP;
			`FUNC_SHL: rAluOp = `ALU_ALS;
			`FUNC_SHR: rAluOp = `ALU_ARS;
			default:   rAluOp = `ALU_ZERO;
		endcase
	end

	always_comb begin
		decoded = '0;
		case (opcode)
			`BNE_OP, `BEQ_OP, `BGZ_OP, `BLZ_OP: decoded[`CTL_BRANCH] = 1'b1;
			`ADI_OP, `ORI_OP: begin
				decoded[`CTL_REG_WRITE] = 1'b1;
				decoded[`CTL_ALU_SRC_IMM] = 1'b1;
				decoded[`CTL_ALU_OP_MSB:`CTL_ALU_OP_LSB] =
					(opcode == `ORI_OP) ? `ALU_OR : `ALU_ADD;
			end
			`LHI_OP: begin
				decoded[`CTL_REG_WRITE] = 1'b1;
				decoded[`CTL_LOAD_UPPER] = 1'b1;
			end
			`LWD_OP: begin
				decoded[`CTL_REG_WRITE] = 1'b1;
				decoded[`CTL_MEM_TO_REG] = 1'b1;
				decoded[`CTL_ALU_SRC_IMM] = 1'b1;  // Effective address rs + imm
				decoded[`CTL_ALU_OP_MSB:`CTL_ALU_OP_LSB] = `ALU_ADD;
			end
			`SWD_OP: begin
				decoded[`CTL_MEM_WRITE] = 1'b1;
				decoded[`CTL_ALU_SRC_IMM] = 1'b1;
				decoded[`CTL_ALU_OP_MSB:`CTL_ALU_OP_LSB] = `ALU_ADD;
			end
			`JMP_OP: decoded[`CTL_JUMP] = 1'b1;
			`JAL_OP: begin
				decoded[`CTL_JUMP] = 1'b1;
				decoded[`CTL_LINK] = 1'b1;
				decoded[`CTL_REG_WRITE] = 1'b1;
			end
			`RTYPE_OP: begin
				case (func)
					`FUNC_ADD, `FUNC_SUB, `FUNC_AND, `FUNC_ORR,
					`FUNC_NOT, `FUNC_TCP, `FUNC_SHL, `FUNC_SHR: begin
						decoded[`CTL_REG_WRITE] = 1'b1;
						decoded[`CTL_ALU_OP_MSB:`CTL_ALU_OP_LSB] = rAluOp;
					end
					`FUNC_WWD: decoded[`CTL_OUTPUT] = 1'b1;
					`FUNC_JPR: decoded[`CTL_PC_FROM_REG] = 1'b1;
					`FUNC_JRL: begin
						decoded[`CTL_PC_FROM_REG] = 1'b1;
						decoded[`CTL_LINK] = 1'b1;
						decoded[`CTL_REG_WRITE] = 1'b1;
					end
					default: decoded = '0;  // HLT and unused codes
				endcase
			end
			default: decoded = '0;
		endcase
	end

	always_comb begin
		case (microState)
			cpuPkg::IF1: nextState = cpuPkg::IF2;
			cpuPkg::IF2: nextState = cpuPkg::IF3;
			cpuPkg::IF3: nextState = isJump ? cpuPkg::EX : cpuPkg::ID;
			cpuPkg::ID:  nextState = isHlt ? cpuPkg::ID : cpuPkg::EX;
			cpuPkg::EX: begin
				if (controls[`CTL_MEM_WRITE] || controls[`CTL_MEM_TO_REG])
					nextState = cpuPkg::MEM1;
				else if (controls[`CTL_REG_WRITE] || controls[`CTL_PC_FROM_REG])
					nextState = cpuPkg::WB;
				else
					nextState = cpuPkg::IF1;  // Branch, JMP and WWD end here
			end
			cpuPkg::MEM1: nextState = cpuPkg::MEM2;
			cpuPkg::MEM2: nextState = controls[`CTL_MEM_TO_REG] ? cpuPkg::WB : cpuPkg::IF1;
			default: nextState = cpuPkg::IF1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			microState <= cpuPkg::IF1;
			controls <= '0;
			numInst <= '0;
			isHalted <= 1'b0;
		end else if (!isHalted) begin  // Everything freezes after HLT
			microState <= nextState;
			if (microState == cpuPkg::IF1)
				numInst <= numInst + 1'b1;
			if (microState == cpuPkg::ID || (microState == cpuPkg::IF3 && isJump))
				controls <= decoded;
			if (microState == cpuPkg::ID && isHlt)
				isHalted <= 1'b1;
		end
	end
endmodule

// File: hdl/datapath.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module datapath (
	input  logic                 clk,
	input  logic                 reset_n,
	input  cpuPkg::microState_t  microState,
	input  cpuPkg::controlWord_t controls,
	input  cpuPkg::word_t        dataIn,
	output cpuPkg::word_t        instruction,
	output cpuPkg::word_t        address,
	output cpuPkg::word_t        dataOut,
	output logic                 readM,
	output logic                 writeM,
	output logic                 outputValid,
	output cpuPkg::word_t        outputPort
);
	cpuPkg::word_t   pc;
	cpuPkg::word_t   ir;
	cpuPkg::word_t   returnPc;
	cpuPkg::word_t   memData;
	cpuPkg::word_t   rsData;
	cpuPkg::word_t   rtData;
	cpuPkg::word_t   signImm;
	cpuPkg::word_t   zeroImm;
	cpuPkg::word_t   aluB;
	cpuPkg::word_t   aluResult;
	cpuPkg::word_t   branchTarget;
	cpuPkg::word_t   jumpTarget;
	cpuPkg::word_t   writeData;
	cpuPkg::regIdx_t writeIdx;
	cpuPkg::aluOp_t  aluOp;
	cpuPkg::opcode_t opcode;
	logic            fetchState;
	logic            memState;
	logic            branchTaken;
	logic            regWriteEnable;

	assign opcode = ir[15:12];
	assign signImm = {{(`WORD_SIZE-8){ir[7]}}, ir[7:0]};
	assign zeroImm = {{(`WORD_SIZE-8){1'b0}}, ir[7:0]};
	assign aluOp = controls[`CTL_ALU_OP_MSB:`CTL_ALU_OP_LSB];
	assign aluB = !controls[`CTL_ALU_SRC_IMM] ? rtData :
		(aluOp == `ALU_OR) ? zeroImm : signImm;  // ORI zero-extends
	assign branchTarget = pc + signImm;  // pc already holds PC+1 in EX
	assign jumpTarget = {pc[`WORD_SIZE-1:12], ir[11:0]};

	always_comb begin
		case (opcode)
			`BNE_OP: branchTaken = (rsData != rtData);
			`BEQ_OP: branchTaken = (rsData == rtData);
			`BGZ_OP: branchTaken = ($signed(rsData) > 0);
			`BLZ_OP: branchTaken = ($signed(rsData) < 0);
			default: branchTaken = 1'b0;
		endcase
	end

	assign fetchState = (microState == cpuPkg::IF1) || (microState == cpuPkg::IF2) ||
		(microState == cpuPkg::IF3);
	assign memState = (microState == cpuPkg::MEM1) || (microState == cpuPkg::MEM2);

	// Memory idles while reset is held in IF1
	assign readM = (reset_n && fetchState) || (memState && controls[`CTL_MEM_TO_REG]);
	assign writeM = (microState == cpuPkg::MEM1) && controls[`CTL_MEM_WRITE];
	assign address = memState ? aluResult : pc;
	assign dataOut = rtData;
	assign outputValid = (microState == cpuPkg::EX) && controls[`CTL_OUTPUT];
	assign outputPort = rsData;
	assign instruction = ir;

	assign regWriteEnable = (microState == cpuPkg::WB) && controls[`CTL_REG_WRITE];
	assign writeIdx = controls[`CTL_LINK] ? 2'd2 :
		(opcode == `RTYPE_OP) ? ir[7:6] : ir[9:8];
	assign writeData = controls[`CTL_LINK] ? returnPc :
		controls[`CTL_LOAD_UPPER] ? {ir[7:0], 8'h00} :
		controls[`CTL_MEM_TO_REG] ? memData : aluResult;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (microState == cpuPkg::IF2 || microState == cpuPkg::IF3)
				ir <= dataIn;  // Fetched word is stable from IF2 on
			if (microState == cpuPkg::IF3) begin
				pc <= pc + 1'b1;
			end else if (microState == cpuPkg::EX) begin
				if (controls[`CTL_JUMP])
					pc <= jumpTarget;
				else if (controls[`CTL_PC_FROM_REG])
					pc <= rsData;  // JPR and JRL
				else if (controls[`CTL_BRANCH] && branchTaken)
					pc <= branchTarget;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (microState == cpuPkg::IF3)
			returnPc <= pc + 1'b1;  // Link value survives the jump
		if (microState == cpuPkg::MEM2)
			memData <= dataIn;
	end

	registerFile registerFile_i (
		.clk(clk),
		.reset_n(reset_n),
		.readIdx1(ir[11:10]),
		.readIdx2(ir[9:8]),
		.writeIdx(writeIdx),
		.writeEnable(regWriteEnable),
		.writeData(writeData),
		.readData1(rsData),
		.readData2(rtData)
	);

	alu alu_i (
		.a(rsData),
		.b(aluB),
		.op(aluOp),
		.result(aluResult)
	);
endmodule

// File: hdl/cpu.sv
`timescale 1ns/10ps

module cpu (
	input  logic          clk,
	input  logic          reset_n,
	input  cpuPkg::word_t dataIn,
	output logic          readM,
	output logic          writeM,
	output cpuPkg::word_t address,
	output cpuPkg::word_t dataOut,
	output cpuPkg::word_t outputPort,
	output logic          outputValid,
	output cpuPkg::word_t numInst,
	output logic          isHalted
);
	cpuPkg::word_t        instruction;
	cpuPkg::microState_t  microState;
	cpuPkg::controlWord_t controls;

	controlUnit controlUnit_i (
		.clk(clk),
		.reset_n(reset_n),
		.instruction(instruction),
		.microState(microState),
		.controls(controls),
		.numInst(numInst),
		.isHalted(isHalted)
	);

	datapath datapath_i (
		.clk(clk),
		.reset_n(reset_n),
		.microState(microState),
		.controls(controls),
		.dataIn(dataIn),
		.instruction(instruction),
		.address(address),
		.dataOut(dataOut),
		.readM(readM),
		.writeM(writeM),
		.outputValid(outputValid),
		.outputPort(outputPort)
	);
endmodule

// File: dv/memoryModel.sv
`timescale 1ns/10ps
`include "cpu_macros.svh"

module memoryModel (
	input  logic          clk,
	input  logic          readM,
	input  logic          writeM,
	input  cpuPkg::word_t address,
	input  cpuPkg::word_t writeData,
	output cpuPkg::word_t readData
);
	localparam int PROG_LEN = 57;
	localparam logic [15:0] PROGRAM [PROG_LEN] = '{
		16'h4005, 16'hF01C, 16'h6112, 16'h5534, 16'hF41C, 16'hF180, 16'hF81C, 16'hF1C1,
		16'hFC1C, 16'hF782, 16'hF883, 16'hF81C, 16'hF484, 16'hF81C, 16'hF085, 16'hF81C,
		16'hFC86, 16'hF81C, 16'hFC87, 16'hF81C, 16'h813B, 16'h723B, 16'hF81C, 16'h0101,
		16'hFC1C, 16'h1101, 16'hF01C, 16'h1501, 16'hFC1C, 16'h2001, 16'hFC1C, 16'h2C01,
		16'hF41C, 16'h3C01, 16'hF01C, 16'h3001, 16'h0501, 16'h9028, 16'hFC1C, 16'hFC1C,
		16'hA02C, 16'hFC1C, 16'hFC1C, 16'hFC1C, 16'hF81C, 16'h412D, 16'hF419, 16'hFC1C,
		16'hFC1C, 16'hFC1C, 16'h4132, 16'hF41A, 16'hFC1C, 16'hFC1C, 16'hFC1C, 16'hF81C,
		16'hF01D
	};

	cpuPkg::word_t mem [`MEM_DEPTH];
	logic [7:0]    addrReg;

	initial begin
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			mem[i] = (16'(i) * 16'h0101) ^ 16'h5A5A;  // Data area fill
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			mem[i] = PROGRAM[i];
		end
		addrReg = '0;
	end

	assign readData = mem[addrReg];  // Held until the next read

	always_ff @(posedge clk) begin
		if (readM)
			addrReg <= address[7:0];
		if (writeM)
			mem[address[7:0]] <= writeData;
	end
endmodule

// File: dv/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;
	localparam int MAX_CYCLES = 1000;
	localparam int NUM_OUTPUTS = 14;
	localparam logic [15:0] EXPECTED_OUT [NUM_OUTPUTS] = '{
		16'h0005, 16'h1234, 16'h1239, 16'hEDD1, 16'h0015, 16'hEDCB, 16'hFFFB,
		16'hDBA2, 16'hF6E8, 16'h1234, 16'h0005, 16'h1234, 16'h0029, 16'h0034
	};
	localparam logic [15:0] EXPECTED_INST = 16'd42;  // Instructions executed incl. HLT

	logic          clk;
	logic          reset_n;
	cpuPkg::word_t dataIn;
	logic          readM;
	logic          writeM;
	cpuPkg::word_t address;
	cpuPkg::word_t dataOut;
	cpuPkg::word_t outputPort;
	logic          outputValid;
	cpuPkg::word_t numInst;
	logic          isHalted;
	int            outIdx;
	int            writeCount;
	int            cycleCount;

	cpu dut_i (
		.clk(clk),
		.reset_n(reset_n),
		.dataIn(dataIn),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.dataOut(dataOut),
		.outputPort(outputPort),
		.outputValid(outputValid),
		.numInst(numInst),
		.isHalted(isHalted)
	);

	memoryModel memoryModel_i (
		.clk(clk),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.writeData(dataOut),
		.readData(dataIn)
	);

	task automatic reportMismatch(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		reset_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 reset_n = 1'b1;  // Released just after the edge
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (outputValid)
			outIdx <= outIdx + 1;
		if (writeM)
			writeCount <= writeCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("Timeout: the CPU did not halt within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

	initial begin
		outIdx = 0;
		writeCount = 0;
		cycleCount = 0;
		wait (isHalted === 1'b1);
		repeat (10) @(posedge clk);  // Let the post-halt checks run a while
		$display("TEST RESULT: PASS");
		$finish;
	end

	// Reset and first cycle after release
	assert property (@(posedge clk) (!reset_n || !$past(reset_n)) |->
		!writeM && !outputValid && !isHalted)
		else reportMismatch("reset strobes", 16'h0, 16'({$sampled(writeM),
			$sampled(outputValid), $sampled(isHalted)}));
	assert property (@(posedge clk) (!reset_n || !$past(reset_n)) |-> numInst == 16'd0)
		else reportMismatch("numInst", 16'd0, $sampled(numInst));
	assert property (@(posedge clk) (reset_n && !$past(reset_n)) |-> readM)
		else reportMismatch("readM", 16'd1, 16'($sampled(readM)));

	// WWD results against the hand-worked table
	assert property (@(posedge clk) outputValid |-> outIdx < NUM_OUTPUTS)
		else begin
			$display("Unexpected WWD output beyond the %0d table entries", NUM_OUTPUTS);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	assert property (@(posedge clk) outputValid && outIdx < NUM_OUTPUTS |->
		outputPort == EXPECTED_OUT[outIdx])
		else reportMismatch("outputPort", EXPECTED_OUT[$sampled(outIdx)], $sampled(outputPort));

	// Store to 0x40 of r1
	assert property (@(posedge clk) writeM |-> address == 16'h0040)
		else reportMismatch("address", 16'h0040, $sampled(address));
	assert property (@(posedge clk) writeM |-> dataOut == 16'h1234)
		else reportMismatch("dataOut", 16'h1234, $sampled(dataOut));
	assert property (@(posedge clk) writeM |=> !writeM)
		else reportMismatch("writeM", 16'd0, 16'($sampled(writeM)));

	// Halt behavior
	assert property (@(posedge clk) isHalted |=> isHalted)
		else reportMismatch("isHalted", 16'd1, 16'($sampled(isHalted)));
	assert property (@(posedge clk) isHalted |-> !readM && !writeM && !outputValid)
		else reportMismatch("halted strobes", 16'h0, 16'({$sampled(readM), $sampled(writeM),
			$sampled(outputValid)}));
	assert property (@(posedge clk) $rose(isHalted) |-> numInst == EXPECTED_INST)
		else reportMismatch("numInst", EXPECTED_INST, $sampled(numInst));
	assert property (@(posedge clk) $rose(isHalted) |-> outIdx == NUM_OUTPUTS)
		else reportMismatch("WWD count", 16'(NUM_OUTPUTS), 16'($sampled(outIdx)));
	assert property (@(posedge clk) $rose(isHalted) |-> writeCount == 1)
		else reportMismatch("store count", 16'd1, 16'($sampled(writeCount)));
endmodule

// File: project.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/controlUnit.sv
hdl/datapath.sv
hdl/cpu.sv
dv/memoryModel.sv
dv/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpuTb \
	-Mdir obj_dir -o cpuSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
exit 0
